//--- src.f
hdl/rv32_pkg.sv
hdl/lsq_pkg.sv
hdl/lsq_alloc_ctrl.sv
hdl/lsq_slot.sv
hdl/lsq_mem_port.sv
hdl/load_store_queue.sv
bench/lsq_properties.sv
bench/tb_load_store_queue.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_load_store_queue
FILELIST  ?= src.f
LOG       ?= sim.log
SIM       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the regression, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/lsq_stimulus.txt
# D st f3 tag qj vj qk vk imm | C lane tag val | S n | N n idle | R st tag | F | M addr data
# L tag val | W addr mask data | K full almost_full | H stall | I wait idle (values in hex)
K 0 0
N 3
M 00000100 8091a2f3
M 00000200 12345678
L 1 fffffff3
D 0 0 1 0 00000100 0 0 00000000
L 2 000000f3
D 0 4 2 0 00000100 0 0 00000000
L 3 ffffa2f3
D 0 1 3 0 00000100 0 0 00000000
L 4 0000a2f3
D 0 5 4 0 00000100 0 0 00000000
L 5 8091a2f3
D 0 2 5 0 000000f0 0 0 00000010
L 6 00000078
D 0 0 6 0 000001f8 0 0 00000008
L 7 00005678
D 0 1 7 0 00000200 0 0 00000000
I
# operands waiting on the cdb
D 0 2 4 5 00000000 0 0 00000000
N 3
L 4 12345678
C 1 5 00000200
S 1
I
L 7 000000f3
C 0 6 00000100
D 0 4 7 6 00000000 0 0 00000000
I
R 0 0
D 1 2 8 0 00000300 9 00000000 00000000
C 1 9 cafef00d
S 1
N 3
W 00000300 f cafef00d
R 1 8
I
L 9 cafef00d
D 0 2 9 0 00000300 0 0 00000000
I
# stores held until the rob head matches
R 0 0
D 1 0 3 0 00000400 0 000000ab 00000004
N 4
W 00000404 1 000000ab
R 1 3
I
D 1 1 5 0 00000408 0 1234beef 00000000
W 00000408 3 1234beef
R 1 5
I
L 6 fffffbab
D 0 2 6 0 00000404 0 0 00000000
L 7 ffffbeef
D 0 2 7 0 00000408 0 0 00000000
I
# stalled cache fills the queue, ninth dispatch dropped
H 1
L 1 8091a2f3
D 0 2 1 0 00000100 0 0 00000000
L 2 8091a2f3
D 0 2 2 0 00000100 0 0 00000000
L 3 8091a2f3
D 0 2 3 0 00000100 0 0 00000000
L 4 8091a2f3
D 0 2 4 0 00000100 0 0 00000000
L 5 8091a2f3
D 0 2 5 0 00000100 0 0 00000000
K 0 0
L 6 8091a2f3
D 0 2 6 0 00000100 0 0 00000000
K 0 1
L 7 8091a2f3
D 0 2 7 0 00000100 0 0 00000000
K 1 1
L 8 8091a2f3
D 0 2 8 0 00000100 0 0 00000000
D 0 2 9 0 00000100 0 0 00000000
K 1 1
H 0
I
L a 12345678
D 0 2 a 0 00000200 0 0 00000000
I
# flush discards pending loads
H 1
D 0 2 1 0 00000100 0 0 00000000
D 0 2 2 0 00000100 0 0 00000000
F
H 0
N 4
K 0 0
L 3 12345678
D 0 2 3 0 00000200 0 0 00000000
I

//--- bench/tb_load_store_queue.sv
`timescale 1ns/10ps
`default_nettype none

module tb_load_store_queue;

    logic                  clk;
    logic                  reset;
    logic                  flush;
    lsq_pkg::lsq_alloc_t   alloc;
    lsq_pkg::cdb_t         cdb;
    logic                  rob_head_is_store;
    lsq_pkg::rob_tag_t     rob_head_tag;
    logic                  store_complete;
    lsq_pkg::mem_req_t     mem_req;
    logic                  mem_resp;
    rv32_pkg::word_t       mem_rdata;
    lsq_pkg::load_result_t load_result;
    logic                  full;
    logic                  almost_full;

    // cache model
    rv32_pkg::word_t mem [rv32_pkg::word_t];
    logic [31:0]     rng_state;
    int              resp_wait;
    logic            stall;
    logic            stall_seen;

    lsq_pkg::load_result_t exp_loads [$];
    lsq_pkg::mem_req_t     exp_stores [$];
    lsq_pkg::load_result_t ld_exp;
    lsq_pkg::mem_req_t     st_exp;
    int                    stores_unacked;
    int                    cycles;
    int                    cycle_limit;
    logic                  forbid_req;
    int                    fd;
    int                    rc;
    int                    n_lines;
    string                 cmd;
    string                 line;
    logic [31:0]           arg [8];

    load_store_queue uut (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .alloc             (alloc),
        .cdb               (cdb),
        .rob_head_is_store (rob_head_is_store),
        .rob_head_tag      (rob_head_tag),
        .store_complete    (store_complete),
        .mem_req           (mem_req),
        .mem_resp          (mem_resp),
        .mem_rdata         (mem_rdata),
        .load_result       (load_result),
        .full              (full),
        .almost_full       (almost_full)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // untouched words read back as the inverted address
    function automatic rv32_pkg::word_t read_word(input rv32_pkg::word_t addr);
        rv32_pkg::word_t a;
        a = addr & ~32'h3;
        if (mem.exists(a)) begin
            return mem[a];
        end
        return ~a;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_load(input lsq_pkg::load_result_t got,
                              input lsq_pkg::load_result_t exp);
        if (got.tag !== exp.tag || got.value !== exp.value) begin
            fail_run($sformatf("ERROR at %0t: load tag %0d value %h, expected tag %0d value %h",
                               $time, got.tag, got.value, exp.tag, exp.value));
        end
    endtask

    task automatic check_store(input lsq_pkg::mem_req_t got, input lsq_pkg::mem_req_t exp);
        if (got.addr !== exp.addr || got.mask !== exp.mask || got.wdata !== exp.wdata) begin
            fail_run($sformatf("ERROR at %0t: store %h/%b/%h, expected %h/%b/%h", $time,
                               got.addr, got.mask, got.wdata, exp.addr, exp.mask, exp.wdata));
        end
    endtask

    task automatic check_flags(input logic got_full, input logic got_af,
                               input logic exp_full, input logic exp_af);
        if (got_full !== exp_full || got_af !== exp_af) begin
            fail_run($sformatf("ERROR at %0t: full %b almost_full %b, expected %b %b",
                               $time, got_full, got_af, exp_full, exp_af));
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // answer after 0 to 3 cycles unless stalled
    always @(posedge clk) begin
        stall_seen = stall;
        #1;
        mem_resp = 1'b0;
        if (reset || !(mem_req.read || mem_req.write)) begin
            resp_wait = -1;
        end else if (!stall_seen) begin
            if (resp_wait < 0) begin
                rng_state = xorshift(rng_state);
                resp_wait = int'(rng_state % 32'd4);
            end
            if (resp_wait == 0) begin
                mem_resp  = 1'b1;
                resp_wait = -1;
                if (mem_req.read) begin
                    mem_rdata = read_word(mem_req.addr);
                end else begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_req.mask[b]) begin
                            mem_rdata = read_word(mem_req.addr);
                            mem_rdata[b*8 +: 8] = mem_req.wdata[b*8 +: 8];
                            mem[mem_req.addr & ~32'h3] = mem_rdata;
                        end
                    end
                end
            end else begin
                resp_wait--;
            end
        end
    end

    always @(negedge clk) begin
        if (!reset && forbid_req && (mem_req.read || mem_req.write)) begin
            fail_run("A memory request appeared while the queue should stay idle");
        end
    end

    always @(negedge clk) begin
        if (!reset && mem_req.write && mem_resp) begin
            if (exp_stores.size() == 0) begin
                fail_run("A store was written that the test did not expect");
            end else begin
                check_store(mem_req, exp_stores.pop_front());
                stores_unacked++;
            end
        end
    end

    always @(negedge clk) begin
        if (!reset && store_complete) begin
            if (stores_unacked == 0) begin
                fail_run("Store complete pulsed with no store written");
            end else begin
                stores_unacked--;
            end
        end
    end

    always @(negedge clk) begin
        if (!reset && load_result.valid) begin
            if (exp_loads.size() == 0) begin
                fail_run("A load result appeared that the test did not expect");
            end else begin
                check_load(load_result, exp_loads.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            fail_run("Timeout: the run went past its cycle limit");
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        flush = 1'b0;
        alloc = '0;
        cdb = '0;
        rob_head_is_store = 1'b0;
        rob_head_tag = '0;
        mem_resp = 1'b0;
        mem_rdata = '0;
        rng_state = 32'he8bb;
        resp_wait = -1;
        stall = 1'b0;
        stores_unacked = 0;
        cycles = 0;
        cycle_limit = 0;
        forbid_req = 1'b0;
        n_lines = 0;
        fd = $fopen("bench/lsq_stimulus.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the stimulus file bench/lsq_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                n_lines++;
            end
            $fclose(fd);
            cycle_limit = 16 + 40 * n_lines;
            fd = $fopen("bench/lsq_stimulus.txt", "r");
            repeat (16) @(posedge clk);
            #1;
            reset = 1'b0;
            while ($fscanf(fd, "%s", cmd) == 1) begin
                case (cmd)
                    "#": rc = $fgets(line, fd);
                    "D": begin
                        rc = $fscanf(fd, "%h %h %h %h %h %h %h %h", arg[0], arg[1], arg[2],
                                     arg[3], arg[4], arg[5], arg[6], arg[7]);
                        alloc.valid    = 1'b1;
                        alloc.is_store = arg[0][0];
                        alloc.funct3   = arg[1][2:0];
                        alloc.tag      = arg[2][3:0];
                        alloc.qj       = arg[3][3:0];
                        alloc.vj       = arg[4];
                        alloc.qk       = arg[5][3:0];
                        alloc.vk       = arg[6];
                        alloc.imm      = arg[7];
                        step();
                        alloc.valid = 1'b0;
                        cdb = '0;
                    end
                    "C": begin
                        rc = $fscanf(fd, "%h %h %h", arg[0], arg[1], arg[2]);
                        cdb[arg[0][0]].valid = 1'b1;
                        cdb[arg[0][0]].tag   = arg[1][3:0];
                        cdb[arg[0][0]].value = arg[2];
                    end
                    "S": begin
                        rc = $fscanf(fd, "%d", arg[0]);
                        repeat (arg[0]) step();
                        cdb = '0;
                    end
                    "N": begin
                        rc = $fscanf(fd, "%d", arg[0]);
                        forbid_req = 1'b1;
                        repeat (arg[0]) step();
                        forbid_req = 1'b0;
                    end
                    "R": begin
                        rc = $fscanf(fd, "%h %h", arg[0], arg[1]);
                        rob_head_is_store = arg[0][0];
                        rob_head_tag      = arg[1][3:0];
                    end
                    "F": begin
                        flush = 1'b1;
                        step();
                        flush = 1'b0;
                    end
                    "M": begin
                        rc = $fscanf(fd, "%h %h", arg[0], arg[1]);
                        mem[arg[0] & ~32'h3] = arg[1];
                    end
                    "L": begin
                        rc = $fscanf(fd, "%h %h", arg[0], arg[1]);
                        ld_exp = '0;
                        ld_exp.valid = 1'b1;
                        ld_exp.tag   = arg[0][3:0];
                        ld_exp.value = arg[1];
                        exp_loads.push_back(ld_exp);
                    end
                    "W": begin
                        rc = $fscanf(fd, "%h %h %h", arg[0], arg[1], arg[2]);
                        st_exp = '0;
                        st_exp.write = 1'b1;
                        st_exp.addr  = arg[0];
                        st_exp.mask  = arg[1][3:0];
                        st_exp.wdata = arg[2];
                        exp_stores.push_back(st_exp);
                    end
                    "K": begin
                        rc = $fscanf(fd, "%h %h", arg[0], arg[1]);
                        check_flags(full, almost_full, arg[0][0], arg[1][0]);
                    end
                    "H": begin
                        rc = $fscanf(fd, "%h", arg[0]);
                        stall = arg[0][0];
                    end
                    "I": begin
                        while (exp_loads.size() != 0 || exp_stores.size() != 0
                               || stores_unacked != 0 || mem_req.read || mem_req.write) begin
                            step();
                        end
                    end
                    default: begin
                        fail_run($sformatf("Unknown command %s in the stimulus file", cmd));
                    end
                endcase
            end
            $fclose(fd);
            if (exp_loads.size() != 0 || exp_stores.size() != 0 || stores_unacked != 0) begin
                fail_run("Expected results were still outstanding at the end of the stimulus");
            end else begin
                $display("Regression passed");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/lsq_properties.sv
`timescale 1ns/10ps
`default_nettype none

module lsq_properties (
    input logic                  clk,
    input logic                  reset,
    input logic                  flush,
    input lsq_pkg::mem_req_t     mem_req,
    input logic                  mem_resp,
    input logic                  rob_head_is_store,
    input lsq_pkg::rob_tag_t     rob_head_tag,
    input lsq_pkg::slot_state_t  head,
    input lsq_pkg::load_result_t load_result,
    input logic                  store_complete
);

    // request held steady until the cache answers
    assert property (@(posedge clk) disable iff (reset || flush)
        (mem_req.read || mem_req.write) && !mem_resp |=> $stable(mem_req))
        else $error("memory request changed before the response");

    assert property (@(posedge clk) disable iff (reset)
        !(mem_req.read && mem_req.write))
        else $error("read and write requested together");

    // a write starts only for the store at the rob head
    assert property (@(posedge clk) disable iff (reset || flush)
        $rose(mem_req.write) |-> $past(rob_head_is_store && (rob_head_tag == head.tag)))
        else $error("write issued without a matching rob head");

    assert property (@(posedge clk) disable iff (reset)
        load_result.valid |=> !load_result.valid)
        else $error("load result valid for more than one cycle");

    assert property (@(posedge clk) disable iff (reset)
        store_complete |=> !store_complete)
        else $error("store complete held for more than one cycle");

endmodule

bind lsq_mem_port lsq_properties u_properties (
    .clk               (clk),
    .reset             (reset),
    .flush             (flush),
    .mem_req           (mem_req),
    .mem_resp          (mem_resp),
    .rob_head_is_store (rob_head_is_store),
    .rob_head_tag      (rob_head_tag),
    .head              (head),
    .load_result       (load_result),
    .store_complete    (store_complete)
);

`default_nettype wire

//--- hdl/load_store_queue.sv
`timescale 1ns/10ps
`default_nettype none

module load_store_queue (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  lsq_pkg::lsq_alloc_t   alloc,
    input  lsq_pkg::cdb_t         cdb,
    input  logic                  rob_head_is_store,
    input  lsq_pkg::rob_tag_t     rob_head_tag,
    output logic                  store_complete,
    output lsq_pkg::mem_req_t     mem_req,
    input  logic                  mem_resp,
    input  rv32_pkg::word_t       mem_rdata,
    output lsq_pkg::load_result_t load_result,
    output logic                  full,
    output logic                  almost_full
);

    logic [lsq_pkg::LSQ_DEPTH-1:0] slot_write;
    lsq_pkg::slot_idx_t            head_idx;
    logic                          retire;
    lsq_pkg::slot_state_t          slot_states [lsq_pkg::LSQ_DEPTH];

    lsq_alloc_ctrl u_alloc_ctrl (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .alloc_valid (alloc.valid),
        .retire      (retire),
        .slot_write  (slot_write),
        .head_idx    (head_idx),
        .full        (full),
        .almost_full (almost_full)
    );

    // only the slot under the head pointer sees the retire pulse
    for (genvar i = 0; i < lsq_pkg::LSQ_DEPTH; i++) begin : g_slot
        lsq_slot u_slot (
            .clk   (clk),
            .reset (reset),
            .flush (flush),
            .write (slot_write[i]),
            .alloc (alloc),
            .cdb   (cdb),
            .free  (retire && (head_idx == lsq_pkg::slot_idx_t'(i))),
            .state (slot_states[i])
        );
    end

    lsq_mem_port u_mem_port (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .slots             (slot_states),
        .head_idx          (head_idx),
        .rob_head_is_store (rob_head_is_store),
        .rob_head_tag      (rob_head_tag),
        .mem_resp          (mem_resp),
        .mem_rdata         (mem_rdata),
        .mem_req           (mem_req),
        .load_result       (load_result),
        .store_complete    (store_complete),
        .retire            (retire)
    );

endmodule

`default_nettype wire

//--- hdl/lsq_mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module lsq_mem_port (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  lsq_pkg::slot_state_t  slots [lsq_pkg::LSQ_DEPTH],
    input  lsq_pkg::slot_idx_t    head_idx,
    input  logic                  rob_head_is_store,
    input  lsq_pkg::rob_tag_t     rob_head_tag,
    input  logic                  mem_resp,
    input  rv32_pkg::word_t       mem_rdata,
    output lsq_pkg::mem_req_t     mem_req,
    output lsq_pkg::load_result_t load_result,
    output logic                  store_complete,
    output logic                  retire
);

    lsq_pkg::slot_state_t head;
    logic                 in_flight;
    logic                 load_go;
    logic                 store_go;
    rv32_pkg::word_t      eff_addr;
    rv32_pkg::byte_mask_t store_mask;
    rv32_pkg::word_t      load_value;

    assign head      = slots[head_idx];
    assign in_flight = mem_req.read || mem_req.write;

    assign load_go = head.busy && !head.is_store && head.qj_ready;

    // stores wait until the rob has this very store at its head
    assign store_go = head.busy && head.is_store && head.qj_ready && head.qk_ready
                      && rob_head_is_store && (rob_head_tag == head.tag);

    assign eff_addr = head.base + head.imm;

    // sub-word stores use the low lanes only
    always_comb begin
        case (rv32_pkg::store_funct3_t'(head.funct3))
            rv32_pkg::sb: store_mask = 4'b0001;
            rv32_pkg::sh: store_mask = 4'b0011;
            default:      store_mask = 4'b1111;
        endcase
    end

    always_comb begin
        case (rv32_pkg::load_funct3_t'(head.funct3))
            rv32_pkg::lb:  load_value = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
            rv32_pkg::lh:  load_value = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
            rv32_pkg::lbu: load_value = {24'b0, mem_rdata[7:0]};
            rv32_pkg::lhu: load_value = {16'b0, mem_rdata[15:0]};
            default:       load_value = mem_rdata;
        endcase
    end

    // head slot frees and head pointer moves at the response edge
    assign retire = in_flight && mem_resp;

    always_ff @(posedge clk) begin
        load_result.valid <= 1'b0;
        store_complete    <= 1'b0;
        if (in_flight) begin
            if (mem_resp) begin
                mem_req.read      <= 1'b0;
                mem_req.write     <= 1'b0;
                load_result.valid <= mem_req.read;
                store_complete    <= mem_req.write;
            end
        end else begin
            mem_req.read  <= load_go;
            mem_req.write <= store_go;
        end

        // address and data frozen while the cache works on a request
        if (!in_flight) begin
            mem_req.addr  <= eff_addr;
            mem_req.mask  <= head.is_store ? store_mask : 4'b1111;
            mem_req.wdata <= head.data;
        end
        if (retire) begin
            load_result.tag   <= head.tag;
            load_result.value <= load_value;
        end

        if (reset || flush) begin
            mem_req.read      <= 1'b0;
            mem_req.write     <= 1'b0;
            load_result.valid <= 1'b0;
            store_complete    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/lsq_slot.sv
`timescale 1ns/10ps
`default_nettype none

module lsq_slot (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 write,
    input  lsq_pkg::lsq_alloc_t  alloc,
    input  lsq_pkg::cdb_t        cdb,
    input  logic                 free,
    output lsq_pkg::slot_state_t state
);

    logic               busy;
    lsq_pkg::rob_tag_t  qj;
    lsq_pkg::rob_tag_t  qk;
    lsq_pkg::rob_tag_t  qj_src;
    lsq_pkg::rob_tag_t  qk_src;
    lsq_pkg::rob_tag_t  qj_next;
    lsq_pkg::rob_tag_t  qk_next;
    rv32_pkg::word_t    base;
    rv32_pkg::word_t    data;
    rv32_pkg::word_t    base_next;
    rv32_pkg::word_t    data_next;
    logic               is_store;
    logic [2:0]         funct3;
    lsq_pkg::rob_tag_t  tag;
    rv32_pkg::word_t    imm;

    // operand source is the new instruction on write, else the held one
    always_comb begin
        qj_src    = write ? alloc.qj : qj;
        qk_src    = write ? alloc.qk : qk;
        qj_next   = qj_src;
        qk_next   = qk_src;
        base_next = write ? alloc.vj : base;
        data_next = write ? alloc.vk : data;
        // snoop every cdb lane even in the allocation cycle
        for (int i = 0; i < lsq_pkg::NUM_CDB; i++) begin
            if (cdb[i].valid && qj_src != '0 && cdb[i].tag == qj_src) begin
                qj_next   = '0;
                base_next = cdb[i].value;
            end
            if (cdb[i].valid && qk_src != '0 && cdb[i].tag == qk_src) begin
                qk_next   = '0;
                data_next = cdb[i].value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            busy <= 1'b0;
            qj   <= '0;
            qk   <= '0;
        end else begin
            if (write) begin
                busy <= 1'b1;
            end else if (free) begin
                busy <= 1'b0;
            end
            qj <= qj_next;
            qk <= qk_next;
        end
    end

    always_ff @(posedge clk) begin
        base <= base_next;
        data <= data_next;
        if (write) begin
            is_store <= alloc.is_store;
            funct3   <= alloc.funct3;
            tag      <= alloc.tag;
            imm      <= alloc.imm;
        end
    end

    always_comb begin
        state.busy     = busy;
        state.is_store = is_store;
        state.funct3   = funct3;
        state.tag      = tag;
        state.qj_ready = (qj == '0);
        state.qk_ready = (qk == '0);
        state.base     = base;
        state.data     = data;
        state.imm      = imm;
    end

endmodule

`default_nettype wire

//--- hdl/lsq_alloc_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module lsq_alloc_ctrl (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,
    input  logic                          alloc_valid,
    input  logic                          retire,
    output logic [lsq_pkg::LSQ_DEPTH-1:0] slot_write,
    output lsq_pkg::slot_idx_t            head_idx,
    output logic                          full,
    output logic                          almost_full
);

    // one extra bit so a completely filled queue can be told from an empty one
    typedef logic [$clog2(lsq_pkg::LSQ_DEPTH):0] count_t;

    lsq_pkg::slot_idx_t tail_idx;
    count_t             count;
    logic               accept;

    assign accept = alloc_valid && (count < count_t'(lsq_pkg::LSQ_DEPTH));

    // one-hot strobe for the tail slot
    always_comb begin
        slot_write = '0;
        if (accept) begin
            slot_write[tail_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head_idx <= '0;
            tail_idx <= '0;
            count    <= '0;
        end else begin
            if (accept) begin
                tail_idx <= tail_idx + 1'b1;
            end
            if (retire) begin
                head_idx <= head_idx + 1'b1;
            end
            // simultaneous alloc and retire leave the count as it is
            case ({accept, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // thresholds kept one entry early, as the dispatch stage expects
    assign full        = (count >= count_t'(lsq_pkg::LSQ_DEPTH - 1));
    assign almost_full = (count >= count_t'(lsq_pkg::LSQ_DEPTH - 2));

endmodule

`default_nettype wire

//--- hdl/lsq_pkg.sv
`default_nettype none

package lsq_pkg;

    localparam int LSQ_DEPTH   = 8;
    localparam int ROB_ENTRIES = 16;
    localparam int NUM_CDB     = 2;

    // tag 0 marks an operand that is already known
    typedef logic [$clog2(ROB_ENTRIES)-1:0] rob_tag_t;
    typedef logic [$clog2(LSQ_DEPTH)-1:0]   slot_idx_t;

    typedef struct packed {
        logic            valid;
        rob_tag_t        tag;
        rv32_pkg::word_t value;
    } cdb_lane_t;

    typedef cdb_lane_t [NUM_CDB-1:0] cdb_t;

    // instruction as handed over by dispatch
    typedef struct packed {
        logic            valid;
        logic            is_store;
        logic [2:0]      funct3;
        rob_tag_t        tag;
        rob_tag_t        qj;
        rv32_pkg::word_t vj;
        rob_tag_t        qk;
        rv32_pkg::word_t vk;
        rv32_pkg::word_t imm;
    } lsq_alloc_t;

    // slot contents seen by the memory port
    typedef struct packed {
        logic            busy;
        logic            is_store;
        logic [2:0]      funct3;
        rob_tag_t        tag;
        logic            qj_ready;
        logic            qk_ready;
        rv32_pkg::word_t base;
        rv32_pkg::word_t data;
        rv32_pkg::word_t imm;
    } slot_state_t;

    typedef struct packed {
        logic                 read;
        logic                 write;
        rv32_pkg::byte_mask_t mask;
        rv32_pkg::word_t      addr;
        rv32_pkg::word_t      wdata;
    } mem_req_t;

    typedef struct packed {
        logic            valid;
        rob_tag_t        tag;
        rv32_pkg::word_t value;
    } load_result_t;

endpackage

`default_nettype wire

//--- hdl/rv32_pkg.sv
`default_nettype none

package rv32_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // funct3 codes of the I-type loads
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    // funct3 codes of the S-type stores
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // one enable bit per byte lane
    typedef logic [3:0] byte_mask_t;

endpackage

`default_nettype wire
